// File: source/fxp_pkg.sv
package fxp_pkg;

    // ****************************************
    // Q8.12 signed fixed-point format
    // ****************************************

    // integer bits, sign bit included.
    localparam int FXP_IL = 8;

    // fraction bits, also the shift applied after a multiply.
    localparam int FXP_FL = 12;

    localparam int FXP_WIDTH = FXP_IL + FXP_FL; // total width of one word.

    // one activation or weight word.
    typedef logic signed [FXP_WIDTH-1:0] fxp_t;

    // full product of two words before rescaling.
    typedef logic signed [2*FXP_WIDTH-1:0] fxp_prod_t;

endpackage

// File: source/tile_pkg.sv
package tile_pkg;

    // ****************************************
    // tile geometry
    // ****************************************

    localparam int TILE_ROWS = 4;
    localparam int TILE_COLS = 4;

    // element k sits at row k / TILE_COLS, column k % TILE_COLS.
    localparam int TILE_ELEMS = TILE_ROWS * TILE_COLS;

    // ****************************************
    // masks and slots
    // ****************************************

    // one bit per tile element, bit k for element k.
    typedef logic [TILE_ELEMS-1:0] tile_mask_t;

    // position of a pair after compaction.
    typedef logic [$clog2(TILE_ELEMS)-1:0] slot_idx_t;

endpackage

// File: source/tile_transposer.sv
`timescale 1ns/1ps

module tile_transposer (
    input  logic                                              clk,
    input  logic                                              i_rst_n,
    input  logic                                              i_valid,
    input  logic                                              i_transpose,
    input  fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          i_tile,
    input  fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          i_weights,
    input  tile_pkg::tile_mask_t                              i_act_mask,
    input  tile_pkg::tile_mask_t                              i_wgt_mask,
    output logic                                              o_valid,
    output fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          o_tile,
    output fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          o_weights,
    output tile_pkg::tile_mask_t                              o_act_mask,
    output tile_pkg::tile_mask_t                              o_wgt_mask
);
    import fxp_pkg::*;
    import tile_pkg::*;

    fxp_t [TILE_ELEMS-1:0] xposed;

    always_comb begin
        for (int r = 0; r < TILE_ROWS; r++) begin
            for (int c = 0; c < TILE_COLS; c++) begin
                xposed[r*TILE_COLS + c] = i_tile[c*TILE_COLS + r]; // row and column swap.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid; // one cycle strobe follows the input strobe.
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_tile     <= i_transpose ? xposed : i_tile;
            o_weights  <= i_weights; // weights keep their order in both modes.
            o_act_mask <= i_act_mask;
            o_wgt_mask <= i_wgt_mask;
        end
    end

endmodule

// File: source/sparse_compactor.sv
`timescale 1ns/1ps

module sparse_compactor (
    input  logic                                              clk,
    input  logic                                              i_rst_n,
    input  logic                                              i_valid,
    input  fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          i_tile,
    input  fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          i_weights,
    input  tile_pkg::tile_mask_t                              i_act_mask,
    input  tile_pkg::tile_mask_t                              i_wgt_mask,
    output logic                                              o_valid,
    output fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          o_acts,
    output fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          o_wgts,
    output tile_pkg::tile_mask_t                              o_mask
);
    import fxp_pkg::*;
    import tile_pkg::*;

    tile_mask_t            both_mask;
    slot_idx_t             slot;
    fxp_t [TILE_ELEMS-1:0] packed_acts;
    fxp_t [TILE_ELEMS-1:0] packed_wgts;

    assign both_mask = i_act_mask & i_wgt_mask; // a pair survives only if both sides keep it.

    // ****************************************
    // compaction toward slot 0
    // ****************************************

    always_comb begin
        slot        = '0;
        packed_acts = '0; // slots left over stay at zero.
        packed_wgts = '0;
        for (int k = 0; k < TILE_ELEMS; k++) begin
            if (both_mask[k]) begin
                packed_acts[slot] = i_tile[k];
                packed_wgts[slot] = i_weights[k];
                slot              = slot + 1'b1; // wraps only after the last element.
            end
        end
    end

    // ****************************************
    // output register
    // ****************************************

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_acts <= packed_acts;
            o_wgts <= packed_wgts;
            // the mask keeps element positions for a later scatter.
            o_mask <= both_mask;
        end
    end

endmodule

// File: source/operand_fifo.sv
`timescale 1ns/1ps

module operand_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                              clk,
    input  logic                                              i_rst_n,
    input  logic                                              i_wr,
    input  fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          i_acts,
    input  fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          i_wgts,
    input  tile_pkg::tile_mask_t                              i_mask,
    input  logic                                              i_rd_en,
    output logic                                              o_rd,
    output fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          o_acts,
    output fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          o_wgts,
    output tile_pkg::tile_mask_t                              o_mask,
    output logic                                              o_empty,
    output logic                                              o_full
);
    import fxp_pkg::*;
    import tile_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    fxp_t [TILE_ELEMS-1:0] mem_acts [FIFO_DEPTH];
    fxp_t [TILE_ELEMS-1:0] mem_wgts [FIFO_DEPTH];
    tile_mask_t            mem_mask [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_ok;

    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(FIFO_DEPTH));
    assign o_rd    = i_rd_en && !o_empty;
    assign wr_ok   = i_wr && (!o_full || o_rd); // a read at the same edge frees a slot.

    // head entry is visible in the same cycle as the read strobe.
    assign o_acts = mem_acts[rd_ptr];
    assign o_wgts = mem_wgts[rd_ptr];
    assign o_mask = mem_mask[rd_ptr];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
            if (o_rd) rd_ptr <= rd_ptr + 1'b1;
            if (wr_ok && !o_rd) count <= count + 1'b1;
            else if (o_rd && !wr_ok) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem_acts[wr_ptr] <= i_acts;
            mem_wgts[wr_ptr] <= i_wgts;
            mem_mask[wr_ptr] <= i_mask;
        end
    end

endmodule

// File: source/mac_tree.sv
`timescale 1ns/1ps

module mac_tree (
    input  logic                                              clk,
    input  logic                                              i_rst_n,
    input  logic                                              i_valid,
    input  fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          i_acts,
    input  fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          i_wgts,
    input  tile_pkg::tile_mask_t                              i_mask,
    output logic                                              o_valid,
    output fxp_pkg::fxp_t                                     o_result,
    output tile_pkg::tile_mask_t                              o_mask
);
    import fxp_pkg::*;
    import tile_pkg::*;

    fxp_prod_t  prod_q [TILE_ELEMS];
    tile_mask_t mask_q;
    logic       valid_q;
    fxp_t       sum;

    // ****************************************
    // stage one, full products
    // ****************************************

    always_ff @(posedge clk) begin
        if (i_valid) begin
            for (int k = 0; k < TILE_ELEMS; k++) begin
                prod_q[k] <= $signed(i_acts[k]) * $signed(i_wgts[k]);
            end
            mask_q <= i_mask;
        end
    end

    // ****************************************
    // stage two, rescale and sum
    // ****************************************

    always_comb begin
        sum = '0;
        for (int k = 0; k < TILE_ELEMS; k++) begin
            sum = sum + fxp_t'(prod_q[k] >>> FXP_FL); // low bits only, so overflow wraps.
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            o_result <= sum;
            o_mask   <= mask_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            valid_q <= i_valid;
            o_valid <= valid_q; // two results may be in flight at once.
        end
    end

endmodule

// File: source/sparse_mac_lane.sv
`timescale 1ns/1ps

module sparse_mac_lane #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                              clk,
    input  logic                                              i_rst_n,
    input  fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          i_tile,
    input  fxp_pkg::fxp_t [tile_pkg::TILE_ELEMS-1:0]          i_weights,
    input  tile_pkg::tile_mask_t                              i_act_mask,
    input  tile_pkg::tile_mask_t                              i_wgt_mask,
    input  logic                                              i_transpose,
    input  logic                                              i_valid,
    input  logic                                              i_rd_en,
    output fxp_pkg::fxp_t                                     o_result,
    output tile_pkg::tile_mask_t                              o_result_mask,
    output logic                                              o_result_valid,
    output logic                                              o_empty,
    output logic                                              o_full
);
    import fxp_pkg::*;
    import tile_pkg::*;

    logic                  xp_valid;
    fxp_t [TILE_ELEMS-1:0] xp_tile;
    fxp_t [TILE_ELEMS-1:0] xp_wgts;
    tile_mask_t            xp_act_mask;
    tile_mask_t            xp_wgt_mask;

    logic                  cp_valid;
    fxp_t [TILE_ELEMS-1:0] cp_acts;
    fxp_t [TILE_ELEMS-1:0] cp_wgts;
    tile_mask_t            cp_mask;

    logic                  fifo_rd;
    fxp_t [TILE_ELEMS-1:0] fifo_acts;
    fxp_t [TILE_ELEMS-1:0] fifo_wgts;
    tile_mask_t            fifo_mask;

    tile_transposer u_transposer (
        .clk(clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .i_transpose(i_transpose),
        .i_tile(i_tile), .i_weights(i_weights), .i_act_mask(i_act_mask),
        .i_wgt_mask(i_wgt_mask), .o_valid(xp_valid), .o_tile(xp_tile),
        .o_weights(xp_wgts), .o_act_mask(xp_act_mask), .o_wgt_mask(xp_wgt_mask)
    );

    sparse_compactor u_compactor (
        .clk(clk), .i_rst_n(i_rst_n), .i_valid(xp_valid), .i_tile(xp_tile),
        .i_weights(xp_wgts), .i_act_mask(xp_act_mask), .i_wgt_mask(xp_wgt_mask),
        .o_valid(cp_valid), .o_acts(cp_acts), .o_wgts(cp_wgts), .o_mask(cp_mask)
    );

    operand_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk(clk), .i_rst_n(i_rst_n), .i_wr(cp_valid), .i_acts(cp_acts), .i_wgts(cp_wgts),
        .i_mask(cp_mask), .i_rd_en(i_rd_en), .o_rd(fifo_rd), .o_acts(fifo_acts),
        .o_wgts(fifo_wgts), .o_mask(fifo_mask), .o_empty(o_empty), .o_full(o_full)
    );

    mac_tree u_mac (
        .clk(clk), .i_rst_n(i_rst_n), .i_valid(fifo_rd), .i_acts(fifo_acts),
        .i_wgts(fifo_wgts), .i_mask(fifo_mask), .o_valid(o_result_valid),
        .o_result(o_result), .o_mask(o_result_mask)
    );

endmodule

// File: dv/tb_sparse_mac_lane.sv
`timescale 1ns/1ps

module tb_sparse_mac_lane;
    import fxp_pkg::*;
    import tile_pkg::*;

    typedef fxp_t [TILE_ELEMS-1:0] tile_t;

    localparam int DRAIN_CYCLES    = 20;
    localparam int TILE_CYCLES     = 1 + DRAIN_CYCLES + 4; // send, drain, settle.
    localparam int TEST_CYCLES     = 4 + 14 * TILE_CYCLES + 2 * (16 + TILE_CYCLES);
    localparam int WATCHDOG_CYCLES = 3 + TEST_CYCLES + 100;

    logic       clk;
    logic       rst_n;
    tile_t      tile;
    tile_t      weights;
    tile_mask_t act_mask;
    tile_mask_t wgt_mask;
    logic       transpose;
    logic       valid;
    logic       rd_en;
    fxp_t       result;
    tile_mask_t result_mask;
    logic       result_valid;
    logic       empty;
    logic       full;

    fxp_t       exp_res_q [$];
    tile_mask_t exp_mask_q [$];
    fxp_t       want_res;
    tile_mask_t want_mask;
    tile_t      saved_acts [4];
    tile_t      saved_wgts [4];
    logic [31:0] lfsr = 32'd84141;
    int         errors = 0;
    int         errors_at_start = 0;
    int         test_num = 0;
    int         tests_failed = 0;
    int         results_seen = 0;
    int         run_len = 0;
    int         longest_run = 0;

    sparse_mac_lane #(.FIFO_DEPTH(4)) i_dut (
        .clk(clk), .i_rst_n(rst_n), .i_tile(tile), .i_weights(weights),
        .i_act_mask(act_mask), .i_wgt_mask(wgt_mask), .i_transpose(transpose),
        .i_valid(valid), .i_rd_en(rd_en), .o_result(result), .o_result_mask(result_mask),
        .o_result_valid(result_valid), .o_empty(empty), .o_full(full)
    );

    always #10 clk = ~clk;

    // ****************************************
    // helpers
    // ****************************************

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32, 22, 2, 1.
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic tile_t rand_tile();
        tile_t t;
        for (int k = 0; k < TILE_ELEMS; k++) begin
            t[k] = fxp_t'(rand_bits(FXP_WIDTH));
        end
        return t;
    endfunction

    // expected Q8.12 dot product taken in element order with the masks applied.
    function automatic fxp_t model_sum(input tile_t acts, input tile_t wgts,
                                       input tile_mask_t keep, input logic xpose);
        fxp_t      sum;
        fxp_prod_t p;
        int        src;
        sum = '0;
        for (int k = 0; k < TILE_ELEMS; k++) begin
            src = xpose ? (k % TILE_COLS) * TILE_COLS + k / TILE_COLS : k;
            if (keep[k]) begin
                p   = fxp_prod_t'(acts[src]) * fxp_prod_t'(wgts[k]);
                sum = sum + fxp_t'(p >>> FXP_FL); // wraps to the word width.
            end
        end
        return sum;
    endfunction

    task automatic note_error(input string what);
        errors++;
        $display("ERROR: %s at %0t ns", what, $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        assert (want == got)
        else begin
            errors++;
            $display("FAILED %s expected 0x%0h got 0x%0h", name, want, got);
        end
    endtask

    // called on a falling edge and leaves i_valid high for the caller to drop.
    task automatic drive_tile(input tile_t acts, input tile_t wgts, input tile_mask_t am,
                              input tile_mask_t wm, input logic xpose, input logic kept);
        tile      = acts;
        weights   = wgts;
        act_mask  = am;
        wgt_mask  = wm;
        transpose = xpose;
        valid     = 1'b1;
        if (kept) begin
            exp_res_q.push_back(model_sum(acts, wgts, am & wm, xpose));
            exp_mask_q.push_back(am & wm);
        end
        @(negedge clk);
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (exp_res_q.size() != 0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (exp_res_q.size() != 0) begin
            note_error("expected results were still missing after the drain time");
            exp_res_q.delete();
            exp_mask_q.delete();
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic begin_test();
        test_num++;
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            $display("test %0d %s: pass", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail", test_num, name);
        end
    endtask

    // ****************************************
    // checkers
    // ****************************************

    always @(posedge clk) begin
        if (rst_n) begin
            run_len = result_valid ? run_len + 1 : 0;
            if (run_len > longest_run) longest_run = run_len;
            if (result_valid) begin
                results_seen++;
                if (exp_res_q.size() == 0) begin
                    note_error("a result arrived with no tile waiting for it");
                end else begin
                    want_res  = exp_res_q.pop_front();
                    want_mask = exp_mask_q.pop_front();
                    check_value("o_result", 32'(want_res), 32'(result));
                    check_value("o_result_mask", 32'(want_mask), 32'(result_mask));
                end
            end
        end
    end

    // a tile sampled two edges earlier is written into the empty queue at this edge.
    empty_falls_on_write: assert property (@(posedge clk) disable iff (!rst_n)
        (empty && $past(valid, 2)) |=> !empty)
        else note_error("o_empty stayed high after a tile reached the empty queue");

    valid_follows_read: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> $past(rd_en && !empty, 2))
        else note_error("o_result_valid rose without a read two edges earlier");

    full_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (full && !rd_en) |=> full)
        else note_error("o_full dropped although no read was taken");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    // ****************************************
    // test sequence
    // ****************************************

    initial begin
        tile_mask_t am;
        tile_mask_t wm;
        int         seen;
        clk       = 1'b0;
        rst_n     = 1'b0;
        tile      = '0;
        weights   = '0;
        act_mask  = '0;
        wgt_mask  = '0;
        transpose = 1'b0;
        valid     = 1'b0;
        rd_en     = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        begin_test();
        repeat (4) @(negedge clk);
        check_value("o_empty", 1, 32'(empty));
        check_value("o_full", 0, 32'(full));
        check_value("o_result_valid", 0, 32'(result_valid));
        end_test("reset state");

        begin_test();
        rd_en = 1'b1;
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < TILE_ELEMS; k++) begin
                if (i == 0) begin
                    saved_acts[i][k] = fxp_t'((k + 1) << FXP_FL); // a ramp is clearly asymmetric.
                    saved_wgts[i][k] = fxp_t'((k % 3 + 1) << (FXP_FL - 1));
                end else begin
                    saved_acts[i][k] = fxp_t'(rand_bits(FXP_WIDTH));
                    saved_wgts[i][k] = fxp_t'(rand_bits(FXP_WIDTH));
                end
            end
            drive_tile(saved_acts[i], saved_wgts[i], '1, '1, 1'b0, 1'b1);
            valid = 1'b0;
            wait_drain(DRAIN_CYCLES);
        end
        end_test("direct mode with full masks");

        begin_test();
        for (int i = 0; i < 4; i++) begin
            drive_tile(saved_acts[i], saved_wgts[i], '1, '1, 1'b1, 1'b1);
            valid = 1'b0;
            wait_drain(DRAIN_CYCLES);
        end
        end_test("transposed mode with full masks");

        begin_test();
        for (int i = 0; i < 6; i++) begin
            am = tile_mask_t'(rand_bits(TILE_ELEMS));
            wm = tile_mask_t'(rand_bits(TILE_ELEMS));
            if (i >= 4) am = '0;
            if (i == 5) wm = '0;
            drive_tile(rand_tile(), rand_tile(), am, wm, (i % 2) == 1, 1'b1);
            valid = 1'b0;
            wait_drain(DRAIN_CYCLES);
        end
        end_test("random masks");

        begin_test();
        rd_en = 1'b0;
        seen  = results_seen;
        for (int i = 0; i < 5; i++) begin
            drive_tile(rand_tile(), rand_tile(), '1, '1, 1'b0, i < 4); // the fifth is dropped.
        end
        valid = 1'b0;
        repeat (3) @(negedge clk);
        check_value("o_full", 1, 32'(full));
        check_value("o_empty", 0, 32'(empty));
        check_value("results while reads were off", 0, 32'(results_seen - seen));
        rd_en = 1'b1;
        wait_drain(DRAIN_CYCLES);
        check_value("results after drain", 4, 32'(results_seen - seen));
        check_value("o_empty", 1, 32'(empty));
        check_value("o_full", 0, 32'(full));
        end_test("full queue drops a tile");

        begin_test();
        longest_run = 0;
        for (int i = 0; i < 8; i++) begin
            drive_tile(rand_tile(), rand_tile(), tile_mask_t'(rand_bits(TILE_ELEMS)), '1,
                       1'b0, 1'b1);
        end
        valid = 1'b0;
        wait_drain(DRAIN_CYCLES + 8);
        check_value("o_result_valid run length", 8, 32'(longest_run));
        end_test("back to back streaming");

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 test_num, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sim.f
source/fxp_pkg.sv
source/tile_pkg.sv
source/tile_transposer.sv
source/sparse_compactor.sv
source/operand_fifo.sv
source/mac_tree.sv
source/sparse_mac_lane.sv
dv/tb_sparse_mac_lane.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the sparse MAC lane testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

TOP=tb_sparse_mac_lane
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -f sim.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
